/* Makefile */
VERILATOR = verilator
VFLAGS = --binary --timing --assert -j 0
LINT_FLAGS = --lint-only --timing -Wall
TOP = tb_voice_recorder
RTL_TOP = voice_recorder
FILE_LIST = project.f
OBJ_DIR = obj_dir
LOG = sim.log
PASS_TEXT = Test completed successfully

SOURCES = $(wildcard rtl/*.sv rtl/*.svh tests/*.sv tests/*.svh)

.PHONY: all build run lint clean

all: run

build: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILE_LIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f $(FILE_LIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILE_LIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* project.f */
+incdir+rtl
+incdir+tests
rtl/audio_pkg.sv
rtl/control_pkg.sv
rtl/memory_if.sv
rtl/switch_debounce.sv
rtl/sample_decimator.sv
rtl/recorder_control.sv
rtl/sample_memory.sv
rtl/voice_recorder.sv
tests/tb_voice_recorder.sv

/* rtl/audio_pkg.sv */
package audio_pkg;

	`include "recorder_settings.svh"

	//////////////////////////////
	// sample data path types
	//////////////////////////////

	// one mono audio sample
	typedef logic [`SAMPLE_WIDTH-1:0] sample_t;

	// one location in the sample memory
	typedef logic [`ADDR_WIDTH-1:0] addr_t;

endpackage

/* rtl/control_pkg.sv */
package control_pkg;

	//////////////////////////////
	// recorder control types
	//////////////////////////////

	// recorder mode, set by the debounced button
	typedef enum logic
	{
		MODE_RECORD = 1'b0,
		MODE_PLAYBACK = 1'b1
	} mode_t;

endpackage

/* rtl/memory_if.sv */
`timescale 1ns/100ps

interface memory_if import audio_pkg::*, control_pkg::*;;

	// location for both the write and the synchronous read
	addr_t address;
	// store the live mic sample this cycle
	logic write_enable;
	// update the speaker register this cycle
	logic speaker_load;
	// selects mic or stored data for the speaker
	mode_t mode;

	// control side drives everything
	modport controller
	(
		output address,
		output write_enable,
		output speaker_load,
		output mode
	);

	// memory side only listens
	modport memory
	(
		input address,
		input write_enable,
		input speaker_load,
		input mode
	);

endinterface

/* rtl/recorder_control.sv */
`timescale 1ns/100ps

module recorder_control import audio_pkg::*, control_pkg::*;
(
	input logic clock,
	input logic reset,
	input logic button_level,
	input logic sample_strobe,
	input logic sample_take,
	memory_if.controller mem
);
	// top location, kept empty so a full recording stops here
	localparam addr_t LAST_ADDRESS = '1;

	//////////////////////////////
	// mode FSM
	//////////////////////////////

	mode_t mode;
	mode_t next_mode;
	logic mode_change;

	// button high means playback
	assign next_mode = button_level ? MODE_PLAYBACK : MODE_RECORD;
	assign mode_change = (next_mode != mode);

	// one cycle behind the clean button
	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			mode <= MODE_RECORD;
		end
		else
		begin
			mode <= next_mode;
		end
	end

	//////////////////////////////
	// address counter
	//////////////////////////////

	addr_t address;
	addr_t address_step;
	// first unrecorded location, loop point for playback
	addr_t recording_end;
	logic store;
	logic loop_back;

	assign address_step = address + addr_t'(1);

	// write on a take until the memory is full
	assign store = (mode == MODE_RECORD) && sample_take && (address != LAST_ADDRESS);

	// empty recording parks at 0
	assign loop_back = (recording_end == '0) || (address_step == recording_end);

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			address <= '0;
			recording_end <= '0;
		end
		else if (mode_change)
		begin
			// every mode change rewinds
			address <= '0;
			// remember how far the recording got
			if (next_mode == MODE_PLAYBACK)
			begin
				recording_end <= address;
			end
		end
		else if (mode == MODE_RECORD)
		begin
			// full stop at the top location
			if (store)
			begin
				address <= address_step;
			end
		end
		else if (sample_take)
		begin
			if (loop_back)
			begin
				address <= '0;
			end
			else
			begin
				address <= address_step;
			end
		end
	end

	//////////////////////////////
	// memory controls
	//////////////////////////////

	assign mem.address = address;
	assign mem.write_enable = store;
	assign mem.mode = mode;
	// playback refreshes every strobe, record only on takes
	assign mem.speaker_load = (mode == MODE_PLAYBACK) ? sample_strobe : sample_take;

endmodule

/* rtl/recorder_settings.svh */
`ifndef RECORDER_SETTINGS_SVH
`define RECORDER_SETTINGS_SVH

//////////////////////////////
// audio data
//////////////////////////////

// bits per microphone / speaker sample
`define SAMPLE_WIDTH 8

// sample memory address bits
// 6 gives 64 locations, enough to fill in simulation; raise to 16 on a board
`define ADDR_WIDTH 6

//////////////////////////////
// timing
//////////////////////////////

// codec strobes per stored sample
`define DECIMATION 4

// clock cycles of stable button before the clean level moves
`define DEBOUNCE_CYCLES 16

`endif

/* rtl/sample_decimator.sv */
`timescale 1ns/100ps

`include "recorder_settings.svh"

module sample_decimator
(
	input logic clock,
	input logic reset,
	input logic sample_strobe,
	output logic sample_take
);
	// at least one bit, even with no decimation
	localparam int COUNT_WIDTH = (`DECIMATION > 1) ? $clog2(`DECIMATION) : 1;
	localparam logic [COUNT_WIDTH-1:0] RELOAD = COUNT_WIDTH'(`DECIMATION - 1);

	// strobes left before the next take
	logic [COUNT_WIDTH-1:0] strobe_count;

	// take the strobe that finds the counter empty
	assign sample_take = sample_strobe && (strobe_count == '0);

	// free running, mode changes do not touch it
	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			strobe_count <= RELOAD;
		end
		else if (sample_take)
		begin
			// start the next period
			strobe_count <= RELOAD;
		end
		else if (sample_strobe)
		begin
			strobe_count <= strobe_count - COUNT_WIDTH'(1);
		end
	end

endmodule

/* rtl/sample_memory.sv */
`timescale 1ns/100ps

`include "recorder_settings.svh"

module sample_memory import audio_pkg::*, control_pkg::*;
(
	input logic clock,
	input logic reset,
	input sample_t mic_sample,
	memory_if.memory mem,
	output sample_t speaker_sample
);
	localparam int DEPTH = 2 ** `ADDR_WIDTH;

	//////////////////////////////
	// sample RAM
	//////////////////////////////

	// plain array, synchronous read infers block RAM
	sample_t ram [DEPTH];
	// one cycle behind the address
	sample_t read_data;

	always_ff @(posedge clock)
	begin
		if (mem.write_enable)
		begin
			ram[mem.address] <= mic_sample;
		end
		// read before write on the same location
		read_data <= ram[mem.address];
	end

	//////////////////////////////
	// speaker register
	//////////////////////////////

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			speaker_sample <= '0;
		end
		else if (mem.speaker_load)
		begin
			// record monitors the same value that is being stored
			if (mem.mode == MODE_RECORD)
			begin
				speaker_sample <= mic_sample;
			end
			else
			begin
				speaker_sample <= read_data;
			end
		end
	end

endmodule

/* rtl/switch_debounce.sv */
`timescale 1ns/100ps

`include "recorder_settings.svh"

module switch_debounce
(
	input logic clock,
	input logic reset,
	input logic noisy,
	output logic clean
);
	// counter has to reach the limit itself, hence the +1
	localparam int COUNT_WIDTH = $clog2(`DEBOUNCE_CYCLES + 1);
	localparam logic [COUNT_WIDTH-1:0] COUNT_LIMIT = COUNT_WIDTH'(`DEBOUNCE_CYCLES);

	// last value seen on the raw input
	logic last_seen;
	// cycles since the raw input last moved
	logic [COUNT_WIDTH-1:0] stable_count;

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			// take the button as it is, no waiting at power up
			last_seen <= noisy;
			clean <= noisy;
			stable_count <= '0;
		end
		else if (noisy != last_seen)
		begin
			// input moved, restart the timer
			last_seen <= noisy;
			stable_count <= '0;
		end
		else if (stable_count == COUNT_LIMIT)
		begin
			// stable long enough
			clean <= last_seen;
		end
		else
		begin
			// still waiting
			stable_count <= stable_count + COUNT_WIDTH'(1);
		end
	end

endmodule

/* rtl/voice_recorder.sv */
`timescale 1ns/100ps

module voice_recorder import audio_pkg::*;
(
	input logic clock,
	input logic reset,
	input logic sample_strobe,
	input logic playback_button,
	input sample_t mic_sample,
	output sample_t speaker_sample
);
	// debounced button, high for playback
	logic button_level;
	// every DECIMATION-th strobe
	logic sample_take;

	// control to RAM
	memory_if mem_bus ();

	//////////////////////////////
	// button and pacing
	//////////////////////////////

	switch_debounce button_debounce
	(
		.clock(clock),
		.reset(reset),
		.noisy(playback_button),
		.clean(button_level)
	);

	sample_decimator decimator
	(
		.clock(clock),
		.reset(reset),
		.sample_strobe(sample_strobe),
		.sample_take(sample_take)
	);

	//////////////////////////////
	// control and storage
	//////////////////////////////

	recorder_control control
	(
		.clock(clock),
		.reset(reset),
		.button_level(button_level),
		.sample_strobe(sample_strobe),
		.sample_take(sample_take),
		.mem(mem_bus.controller)
	);

	// RAM plus speaker output register
	sample_memory memory
	(
		.clock(clock),
		.reset(reset),
		.mic_sample(mic_sample),
		.mem(mem_bus.memory),
		.speaker_sample(speaker_sample)
	);

endmodule

/* tests/recorder_model.svh */
`ifndef RECORDER_MODEL_SVH
`define RECORDER_MODEL_SVH

//////////////////////////////
// random source
//////////////////////////////

// 32 bit fibonacci lfsr with taps 32 22 2 1
logic [31:0] lfsr_state;

function automatic logic [31:0] lfsr_next(input logic [31:0] state);
	logic feedback;
	feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
	return {state[30:0], feedback};
endfunction

// one lfsr step per bit taken
function logic [31:0] random_bits(input int count);
	logic [31:0] value;
	value = '0;
	for (int i = 0; i < count; i++)
	begin
		lfsr_state = lfsr_next(lfsr_state);
		value = {value[30:0], lfsr_state[0]};
	end
	return value;
endfunction

//////////////////////////////
// recorder model
//////////////////////////////

localparam int MODEL_DEPTH = 1 << `ADDR_WIDTH;

// strobes left until the next take
int model_count;
mode_t model_mode;
// next location to store or replay
int model_address;
// first location not recorded and loop point for playback
int model_end;
sample_t model_ram [MODEL_DEPTH];
sample_t expected_speaker;

function void clear_model();
	model_count = `DECIMATION - 1;
	model_mode = MODE_RECORD;
	model_address = 0;
	model_end = 0;
	expected_speaker = '0;
endfunction

// debounced mode change rewinds every time
function void follow_button(input mode_t new_mode);
	if (new_mode != model_mode)
	begin
		if (new_mode == MODE_PLAYBACK)
		begin
			model_end = model_address;
		end
		model_address = 0;
		model_mode = new_mode;
	end
endfunction

// one codec strobe carrying a mic sample
function void predict_strobe(input sample_t mic);
	logic take;
	take = (model_count == 0);
	if (take)
	begin
		model_count = `DECIMATION - 1;
	end
	else
	begin
		model_count--;
	end
	if (model_mode == MODE_RECORD)
	begin
		if (take)
		begin
			// speaker echoes every take even with the memory full
			expected_speaker = mic;
			if (model_address < MODEL_DEPTH - 1)
			begin
				model_ram[addr_t'(model_address)] = mic;
				model_address++;
			end
		end
	end
	else
	begin
		// stored sample shown on every strobe
		expected_speaker = model_ram[addr_t'(model_address)];
		if (take)
		begin
			if (model_end == 0 || model_address + 1 == model_end)
			begin
				model_address = 0;
			end
			else
			begin
				model_address++;
			end
		end
	end
endfunction

`endif

/* tests/tb_voice_recorder.sv */
`timescale 1ns/100ps

`include "recorder_settings.svh"

module tb_voice_recorder import audio_pkg::*, control_pkg::*;;

	//////////////////////////////
	// run length
	//////////////////////////////

	// strobes per phase of the run
	localparam int FIRST_RECORD_HALF = 40;
	localparam int FIRST_PLAYBACK = 240;
	localparam int SECOND_RECORD = 50;
	localparam int SECOND_PLAYBACK = 120;
	localparam int FULL_RECORD = 300;
	localparam int FULL_PLAYBACK = 560;
	localparam int TOTAL_STROBES = 2 * FIRST_RECORD_HALF + FIRST_PLAYBACK + SECOND_RECORD
		+ SECOND_PLAYBACK + FULL_RECORD + FULL_PLAYBACK;
	// five mode changes and one glitch
	localparam int BUTTON_EVENTS = 6;
	// at most 6 cycles per strobe plus button waits and some slack
	localparam int WATCHDOG_CYCLES = TOTAL_STROBES * 6
		+ BUTTON_EVENTS * (2 * `DEBOUNCE_CYCLES + 4) + 200;

	logic clock;
	logic reset;
	logic sample_strobe;
	logic playback_button;
	sample_t mic_sample;
	sample_t speaker_sample;

	int error_count;

	`include "recorder_model.svh"

	voice_recorder UUT
	(
		.clock(clock),
		.reset(reset),
		.sample_strobe(sample_strobe),
		.playback_button(playback_button),
		.mic_sample(mic_sample),
		.speaker_sample(speaker_sample)
	);

	// 8 ns period
	initial
	begin
		clock = 1'b0;
		forever
		begin
			#4 clock = ~clock;
		end
	end

	//////////////////////////////
	// stimulus helpers
	//////////////////////////////

	// inputs move 1 ns after the edge
	task automatic next_cycle();
		@(posedge clock);
		#1;
	endtask

	task automatic check_speaker();
		assert (speaker_sample === expected_speaker)
		else
		begin
			$display("Fail: %0d ns speaker_sample expected %h actual %h",
				$time, expected_speaker, speaker_sample);
			error_count++;
		end
	endtask

	// one strobe checked a cycle later and then a random gap
	task automatic send_strobe();
		sample_t mic;
		int gap;
		mic = sample_t'(random_bits(`SAMPLE_WIDTH));
		gap = 3 + random_bits(2);
		sample_strobe = 1'b1;
		mic_sample = mic;
		predict_strobe(mic);
		next_cycle();
		sample_strobe = 1'b0;
		check_speaker();
		repeat (gap - 1) next_cycle();
	endtask

	task automatic run_strobes(input int count);
		for (int i = 0; i < count; i++)
		begin
			send_strobe();
		end
	endtask

	// strobes are paused until the debounced mode has settled
	task automatic set_button(input logic level);
		playback_button = level;
		follow_button(level ? MODE_PLAYBACK : MODE_RECORD);
		repeat (`DEBOUNCE_CYCLES + 4) next_cycle();
	endtask

	// too short for the debouncer so the mode must stay
	task automatic press_short();
		playback_button = 1'b1;
		repeat (`DEBOUNCE_CYCLES / 2) next_cycle();
		playback_button = 1'b0;
		repeat (`DEBOUNCE_CYCLES + 4) next_cycle();
	endtask

	//////////////////////////////
	// test sequence
	//////////////////////////////

	initial
	begin
		reset = 1'b1;
		sample_strobe = 1'b0;
		playback_button = 1'b0;
		mic_sample = '0;
		error_count = 0;
		lfsr_state = 32'hc5b4;
		clear_model();

		repeat (4) @(posedge clock);
		#1;
		reset = 1'b0;
		// speaker cleared by reset
		check_speaker();

		// 20 takes with a glitch on the button half way
		run_strobes(FIRST_RECORD_HALF);
		press_short();
		run_strobes(FIRST_RECORD_HALF);

		// three passes over the 20 samples
		set_button(1'b1);
		run_strobes(FIRST_PLAYBACK);

		// shorter second recording replaces the first
		set_button(1'b0);
		run_strobes(SECOND_RECORD);
		set_button(1'b1);
		run_strobes(SECOND_PLAYBACK);

		// overfill so only 63 samples are kept
		set_button(1'b0);
		run_strobes(FULL_RECORD);
		set_button(1'b1);
		run_strobes(FULL_PLAYBACK);

		$display("checks done, %0d errors", error_count);
		if (error_count == 0)
		begin
			$display("Test completed successfully");
		end
		else
		begin
			$display("Test failed");
		end
		$finish;
	end

	// watchdog
	initial
	begin
		repeat (WATCHDOG_CYCLES) @(posedge clock);
		$display("Watchdog: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("Test failed");
		$finish;
	end

endmodule
